// ==== all.f ====
source/cpu_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_writeback.sv
source/hazard_unit.sv
source/exception_unit.sv
source/cpu_top.sv
test/cpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module cpu_tb -f all.f --Mdir obj_dir -o cpu_sim
./obj_dir/cpu_sim | tee sim.log

if grep -q "^Test completed successfully$" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

// ==== test/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;

	localparam int IMEM_WORDS = 512;
	localparam int RESET_CYCLES = 8;
	localparam int DRAIN_CYCLES = 12;
	// one test takes well under a hundred cycles, reset and drain included.
	localparam int TEST_BUDGET = 400;
	localparam int TIMEOUT_CYCLES = 5 * TEST_BUDGET;
	localparam cpu_pkg::pc_t RESET_PC = '0;
	localparam cpu_pkg::pc_t HANDLER = 32'h100;

	logic clk;
	logic arst_n;
	cpu_pkg::pc_t instr_addr;
	cpu_pkg::instr_t instr;
	cpu_pkg::word_t out_data;
	logic out_valid;
	cpu_pkg::pc_t epc;
	cpu_pkg::cause_t cause;

	cpu_pkg::instr_t imem [IMEM_WORDS];
	cpu_pkg::word_t expected_out [$];
	// register values as the program should leave them.
	cpu_pkg::word_t model [8];
	logic [8:0] prog_pc;
	int cycle_count = 0;
	integer seed;

	cpu_top DUT (
		.clk(clk), .arst_n(arst_n), .instr_addr(instr_addr), .instr(instr),
		.out_data(out_data), .out_valid(out_valid), .epc(epc), .cause(cause)
	);

	// the instruction memory answers in the same cycle and reads as NOP past its end.
	assign instr = (instr_addr < IMEM_WORDS) ? imem[instr_addr[8:0]] : '0;

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input cpu_pkg::word_t got,
		input cpu_pkg::word_t exp);
		if (got !== exp) begin
			fail_run($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_pc(input string name, input cpu_pkg::pc_t got, input cpu_pkg::pc_t exp);
		if (got !== exp) begin
			fail_run($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_cause(input string name, input cpu_pkg::cause_t got,
		input cpu_pkg::cause_t exp);
		if (got !== exp) begin
			fail_run($sformatf("Error at %0t: %s is %s, expected %s", $time, name,
				got.name(), exp.name()));
		end
	endtask

	// every OUT must match the oldest value still awaited.
	always @(negedge clk) begin
		if (arst_n && out_valid) begin
			if (expected_out.size() == 0) begin
				fail_run($sformatf("unexpected OUT of %h at %0t", out_data, $time));
			end else begin
				check_word("out_data", out_data, expected_out.pop_front());
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			fail_run($sformatf("timeout after %0d cycles, %0d outputs never arrived",
				cycle_count, expected_out.size()));
		end
	end

	function automatic cpu_pkg::instr_t enc_rr(cpu_pkg::opcode_t op, cpu_pkg::reg_addr_t rd,
		cpu_pkg::reg_addr_t rs);
		return {op, rd, rs, 6'd0};
	endfunction

	function automatic cpu_pkg::instr_t enc_imm(cpu_pkg::opcode_t op, cpu_pkg::reg_addr_t rd,
		cpu_pkg::word_t imm);
		return {op, rd, imm[8:0]};
	endfunction

	function automatic cpu_pkg::word_t alu_ref(cpu_pkg::opcode_t op, cpu_pkg::word_t d,
		cpu_pkg::word_t s);
		case (op)
			cpu_pkg::OP_MOV: return s;
			cpu_pkg::OP_ADD: return d + s;
			cpu_pkg::OP_SUB: return d - s;
			cpu_pkg::OP_AND: return d & s;
			default: return d | s;
		endcase
	endfunction

	function automatic cpu_pkg::word_t rand_imm();
		int r;
		r = $random(seed);
		return {7'd0, r[8:0]};
	endfunction

	task automatic put(input cpu_pkg::instr_t w);
		imem[prog_pc] = w;
		prog_pc++;
	endtask

	task automatic load_imm(input cpu_pkg::reg_addr_t rd, input cpu_pkg::word_t v);
		put(enc_imm(cpu_pkg::OP_LDI, rd, v));
		model[rd] = v;
	endtask

	task automatic alu(input cpu_pkg::opcode_t op, input cpu_pkg::reg_addr_t rd,
		input cpu_pkg::reg_addr_t rs);
		put(enc_rr(op, rd, rs));
		model[rd] = alu_ref(op, model[rd], model[rs]);
	endtask

	// an OUT on a path the program skips is emitted with seen low.
	task automatic emit_out(input cpu_pkg::reg_addr_t rd, input logic seen);
		put(enc_rr(cpu_pkg::OP_OUT, rd, 3'd0));
		if (seen) begin
			expected_out.push_back(model[rd]);
		end
	endtask

	task automatic clear_program();
		for (int i = 0; i < IMEM_WORDS; i++) begin
			imem[i[8:0]] = '0;
		end
		prog_pc = 9'd0;
	endtask

	task automatic begin_test(input string title);
		@(posedge clk);
		arst_n <= 1'b0;
		@(negedge clk);
		clear_program();
		$display("running %s", title);
	endtask

	task automatic run_program();
		repeat (RESET_CYCLES - 1) @(posedge clk);
		@(negedge clk);
		// the reset state is visible before the program starts.
		check_pc("instr_addr", instr_addr, RESET_PC);
		check_pc("epc", epc, 32'd0);
		check_cause("cause", cause, cpu_pkg::CAUSE_NONE);
		@(posedge clk);
		arst_n <= 1'b1;
		while (expected_out.size() != 0) begin
			@(negedge clk);
		end
		// stray outputs from skipped paths would show up here.
		repeat (DRAIN_CYCLES) @(negedge clk);
	endtask

	task automatic test_alu();
		begin_test("ALU and forwarding");
		load_imm(3'd1, rand_imm());
		load_imm(3'd2, rand_imm());
		alu(cpu_pkg::OP_MOV, 3'd3, 3'd1);
		emit_out(3'd3, 1'b1);
		alu(cpu_pkg::OP_ADD, 3'd3, 3'd2);
		emit_out(3'd3, 1'b1);
		alu(cpu_pkg::OP_SUB, 3'd3, 3'd1);
		emit_out(3'd3, 1'b1);
		alu(cpu_pkg::OP_AND, 3'd3, 3'd2);
		emit_out(3'd3, 1'b1);
		alu(cpu_pkg::OP_OR, 3'd3, 3'd1);
		emit_out(3'd3, 1'b1);
		run_program();
	endtask

	task automatic test_memory();
		for (int i = 0; i < 2; i++) begin
			if (i == 0) begin
				begin_test("memory and load-use");
			end
			load_imm(3'd1, rand_imm() & 16'h00ff);
			load_imm(3'd2, rand_imm());
			put(enc_rr(cpu_pkg::OP_STD, 3'd2, 3'd1));
			load_imm(3'd4, rand_imm());
			// the ADD right after the load needs the loaded word.
			put(enc_rr(cpu_pkg::OP_LDD, 3'd5, 3'd1));
			model[5] = model[2];
			alu(cpu_pkg::OP_ADD, 3'd5, 3'd4);
			emit_out(3'd5, 1'b1);
		end
		run_program();
	endtask

	task automatic test_jumps();
		begin_test("jumps");
		load_imm(3'd1, 16'd5);
		load_imm(3'd2, 16'd3);
		load_imm(3'd6, 16'd40);
		alu(cpu_pkg::OP_ADD, 3'd1, 3'd2);
		put(enc_rr(cpu_pkg::OP_JZ, 3'd6, 3'd0));
		emit_out(3'd1, 1'b1);
		alu(cpu_pkg::OP_SUB, 3'd1, 3'd1);
		put(enc_rr(cpu_pkg::OP_JZ, 3'd6, 3'd0));
		emit_out(3'd1, 1'b0);
		emit_out(3'd1, 1'b0);
		prog_pc = 9'd40;
		emit_out(3'd2, 1'b1);
		load_imm(3'd7, 16'd60);
		put(enc_rr(cpu_pkg::OP_JMP, 3'd7, 3'd0));
		emit_out(3'd1, 1'b0);
		emit_out(3'd1, 1'b0);
		prog_pc = 9'd60;
		emit_out(3'd7, 1'b1);
		run_program();
	endtask

	task automatic test_illegal();
		cpu_pkg::word_t v;
		cpu_pkg::pc_t bad_pc;
		begin_test("illegal opcode");
		v = rand_imm();
		load_imm(3'd1, v);
		emit_out(3'd1, 1'b1);
		load_imm(3'd2, (v + 16'd1) & 16'h01ff);
		bad_pc = {23'd0, prog_pc};
		put({4'd13, 12'd0});
		emit_out(3'd2, 1'b0);
		prog_pc = HANDLER[8:0];
		load_imm(3'd3, (v + 16'd2) & 16'h01ff);
		emit_out(3'd3, 1'b1);
		run_program();
		check_pc("epc", epc, bad_pc);
		check_cause("cause", cause, cpu_pkg::CAUSE_ILLEGAL_OP);
	endtask

	task automatic test_fault();
		cpu_pkg::word_t v;
		cpu_pkg::pc_t bad_pc;
		begin_test("memory fault");
		v = rand_imm();
		// word 44 is where address 300 lands if the upper bits were dropped.
		load_imm(3'd1, 16'd44);
		load_imm(3'd2, v);
		put(enc_rr(cpu_pkg::OP_STD, 3'd2, 3'd1));
		emit_out(3'd2, 1'b1);
		load_imm(3'd3, 16'd300);
		load_imm(3'd4, (v + 16'd1) & 16'h01ff);
		bad_pc = {23'd0, prog_pc};
		put(enc_rr(cpu_pkg::OP_STD, 3'd4, 3'd3));
		emit_out(3'd4, 1'b0);
		prog_pc = HANDLER[8:0];
		load_imm(3'd6, (v + 16'd2) & 16'h01ff);
		emit_out(3'd6, 1'b1);
		put(enc_rr(cpu_pkg::OP_LDD, 3'd7, 3'd1));
		model[7] = v;
		emit_out(3'd7, 1'b1);
		run_program();
		check_pc("epc", epc, bad_pc);
		check_cause("cause", cause, cpu_pkg::CAUSE_MEM_ADDR);
	endtask

	initial begin
		seed = 32'hd456;
		arst_n <= 1'b0;
		clear_program();
		test_alu();
		test_memory();
		test_jumps();
		test_illegal();
		test_fault();
		if (expected_out.size() == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			fail_run("outputs were still awaited at the end of the run");
		end
	end

endmodule

// ==== source/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top #(
	parameter cpu_pkg::pc_t RESET_ADDR = '0,
	parameter cpu_pkg::pc_t HANDLER_ADDR = 32'h100,
	parameter int unsigned DMEM_DEPTH = 256
) (
	input  logic clk,
	input  logic arst_n,
	output cpu_pkg::pc_t instr_addr,
	input  cpu_pkg::instr_t instr,
	output cpu_pkg::word_t out_data,
	output logic out_valid,
	output cpu_pkg::pc_t epc,
	output cpu_pkg::cause_t cause
);

	cpu_pkg::instr_t id_instr;
	cpu_pkg::pc_t id_pc;
	cpu_pkg::opcode_t ex_op;
	cpu_pkg::reg_addr_t ex_rdst;
	cpu_pkg::reg_addr_t ex_rsrc;
	cpu_pkg::word_t ex_a;
	cpu_pkg::word_t ex_b;
	cpu_pkg::word_t ex_imm;
	cpu_pkg::pc_t ex_pc;
	cpu_pkg::opcode_t mem_op;
	cpu_pkg::reg_addr_t mem_rdst;
	cpu_pkg::word_t mem_result;
	cpu_pkg::word_t mem_addr;
	cpu_pkg::pc_t mem_pc;
	cpu_pkg::opcode_t wb_op;
	logic wb_we;
	cpu_pkg::reg_addr_t wb_rdst;
	cpu_pkg::word_t wb_data;
	cpu_pkg::fwd_sel_t fwd_a;
	cpu_pkg::fwd_sel_t fwd_b;
	cpu_pkg::pc_t jump_target;
	logic stall;
	logic jump;
	logic illegal;
	logic addr_fault;
	logic exc_redirect;
	logic flush_id;
	logic flush_ex;
	logic flush_mem;

	fetch_stage #(.RESET_ADDR(RESET_ADDR), .HANDLER_ADDR(HANDLER_ADDR)) u_fetch (
		.clk(clk), .arst_n(arst_n), .instr_addr(instr_addr), .instr(instr),
		.stall(stall), .jump(jump), .jump_target(jump_target),
		.exc_redirect(exc_redirect), .flush_id(flush_id),
		.id_instr(id_instr), .id_pc(id_pc)
	);

	decode_stage u_decode (
		.clk(clk), .arst_n(arst_n), .id_instr(id_instr), .id_pc(id_pc),
		.stall(stall), .flush_ex(flush_ex), .jump(jump),
		.wb_we(wb_we), .wb_rdst(wb_rdst), .wb_data(wb_data), .illegal(illegal),
		.ex_op(ex_op), .ex_rdst(ex_rdst), .ex_rsrc(ex_rsrc), .ex_a(ex_a),
		.ex_b(ex_b), .ex_imm(ex_imm), .ex_pc(ex_pc)
	);

	execute_stage u_execute (
		.clk(clk), .arst_n(arst_n), .ex_op(ex_op), .ex_rdst(ex_rdst), .ex_a(ex_a),
		.ex_b(ex_b), .ex_imm(ex_imm), .ex_pc(ex_pc), .fwd_a(fwd_a), .fwd_b(fwd_b),
		.wb_data(wb_data), .flush_mem(flush_mem), .jump(jump), .jump_target(jump_target),
		.mem_op(mem_op), .mem_rdst(mem_rdst), .mem_result(mem_result),
		.mem_addr(mem_addr), .mem_pc(mem_pc)
	);

	memory_writeback #(.DMEM_DEPTH(DMEM_DEPTH)) u_memwb (
		.clk(clk), .arst_n(arst_n), .mem_op(mem_op), .mem_rdst(mem_rdst),
		.mem_result(mem_result), .mem_addr(mem_addr), .mem_pc(mem_pc),
		.addr_fault(addr_fault), .wb_op(wb_op), .wb_we(wb_we), .wb_rdst(wb_rdst),
		.wb_data(wb_data), .out_valid(out_valid), .out_data(out_data)
	);

	hazard_unit u_hazard (
		.id_instr(id_instr), .ex_op(ex_op), .ex_rdst(ex_rdst), .ex_rsrc(ex_rsrc),
		.mem_op(mem_op), .mem_rdst(mem_rdst), .wb_we(wb_we), .wb_rdst(wb_rdst),
		.fwd_a(fwd_a), .fwd_b(fwd_b), .stall(stall)
	);

	exception_unit u_exception (
		.clk(clk), .arst_n(arst_n), .illegal(illegal), .id_pc(id_pc),
		.addr_fault(addr_fault), .mem_pc(mem_pc), .exc_redirect(exc_redirect),
		.flush_id(flush_id), .flush_ex(flush_ex), .flush_mem(flush_mem),
		.epc(epc), .cause(cause)
	);

endmodule

// ==== source/exception_unit.sv ====
`timescale 1ns/1ps

module exception_unit (
	input  logic clk,
	input  logic arst_n,
	input  logic illegal,
	input  cpu_pkg::pc_t id_pc,
	input  logic addr_fault,
	input  cpu_pkg::pc_t mem_pc,
	output logic exc_redirect,
	output logic flush_id,
	output logic flush_ex,
	output logic flush_mem,
	output cpu_pkg::pc_t epc,
	output cpu_pkg::cause_t cause
);

	// a fault in MEM is older than anything in ID, so it takes priority.
	assign exc_redirect = addr_fault || illegal;
	assign flush_id = exc_redirect;
	assign flush_ex = exc_redirect;
	assign flush_mem = addr_fault;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			epc <= '0;
			cause <= cpu_pkg::CAUSE_NONE;
		end else if (addr_fault) begin
			epc <= mem_pc;
			cause <= cpu_pkg::CAUSE_MEM_ADDR;
		end else if (illegal) begin
			epc <= id_pc;
			cause <= cpu_pkg::CAUSE_ILLEGAL_OP;
		end
	end

endmodule

// ==== source/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
	input  cpu_pkg::instr_t id_instr,
	input  cpu_pkg::opcode_t ex_op,
	input  cpu_pkg::reg_addr_t ex_rdst,
	input  cpu_pkg::reg_addr_t ex_rsrc,
	input  cpu_pkg::opcode_t mem_op,
	input  cpu_pkg::reg_addr_t mem_rdst,
	input  logic wb_we,
	input  cpu_pkg::reg_addr_t wb_rdst,
	output cpu_pkg::fwd_sel_t fwd_a,
	output cpu_pkg::fwd_sel_t fwd_b,
	output logic stall
);

	cpu_pkg::opcode_t id_op;
	cpu_pkg::reg_addr_t id_rdst;
	cpu_pkg::reg_addr_t id_rsrc;
	logic uses_rdst;
	logic uses_rsrc;
	logic mem_fwd_ok;

	assign id_op = cpu_pkg::opcode_t'(id_instr[cpu_pkg::OPCODE_MSB:cpu_pkg::OPCODE_LSB]);
	assign id_rdst = id_instr[cpu_pkg::RDST_MSB:cpu_pkg::RDST_LSB];
	assign id_rsrc = id_instr[cpu_pkg::RSRC_MSB:cpu_pkg::RSRC_LSB];

	assign uses_rdst = id_op inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
		cpu_pkg::OP_OR, cpu_pkg::OP_STD, cpu_pkg::OP_JZ, cpu_pkg::OP_JMP, cpu_pkg::OP_OUT};
	assign uses_rsrc = id_op inside {cpu_pkg::OP_MOV, cpu_pkg::OP_ADD, cpu_pkg::OP_SUB,
		cpu_pkg::OP_AND, cpu_pkg::OP_OR, cpu_pkg::OP_LDD, cpu_pkg::OP_STD};

	// load data is not ready in MEM, so loads only forward from write-back.
	assign mem_fwd_ok = cpu_pkg::writes_reg(mem_op) && (mem_op != cpu_pkg::OP_LDD);

	assign fwd_a = (mem_fwd_ok && mem_rdst == ex_rdst) ? cpu_pkg::FWD_MEM :
		(wb_we && wb_rdst == ex_rdst) ? cpu_pkg::FWD_WB : cpu_pkg::FWD_NONE;
	assign fwd_b = (mem_fwd_ok && mem_rdst == ex_rsrc) ? cpu_pkg::FWD_MEM :
		(wb_we && wb_rdst == ex_rsrc) ? cpu_pkg::FWD_WB : cpu_pkg::FWD_NONE;

	assign stall = (ex_op == cpu_pkg::OP_LDD) &&
		((uses_rdst && id_rdst == ex_rdst) || (uses_rsrc && id_rsrc == ex_rdst));

endmodule

// ==== source/memory_writeback.sv ====
`timescale 1ns/1ps

module memory_writeback #(
	parameter int unsigned DMEM_DEPTH = 256
) (
	input  logic clk,
	input  logic arst_n,
	input  cpu_pkg::opcode_t mem_op,
	input  cpu_pkg::reg_addr_t mem_rdst,
	input  cpu_pkg::word_t mem_result,
	input  cpu_pkg::word_t mem_addr,
	input  cpu_pkg::pc_t mem_pc,
	output logic addr_fault,
	output cpu_pkg::opcode_t wb_op,
	output logic wb_we,
	output cpu_pkg::reg_addr_t wb_rdst,
	output cpu_pkg::word_t wb_data,
	output logic out_valid,
	output cpu_pkg::word_t out_data
);

	localparam int AW = $clog2(DMEM_DEPTH);

	cpu_pkg::word_t dmem [DMEM_DEPTH];
	cpu_pkg::word_t rd_data;
	logic is_access;

	assign is_access = (mem_op == cpu_pkg::OP_LDD) || (mem_op == cpu_pkg::OP_STD);
	assign addr_fault = is_access && (32'(mem_addr) >= DMEM_DEPTH);
	assign rd_data = dmem[mem_addr[AW-1:0]];

	always_ff @(posedge clk) begin
		if (mem_op == cpu_pkg::OP_STD && !addr_fault) begin
			dmem[mem_addr[AW-1:0]] <= mem_result;
		end
	end

	// a faulting access enters write-back as a NOP, so a bad load writes nothing.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_op <= cpu_pkg::OP_NOP;
			wb_rdst <= '0;
			wb_data <= '0;
			out_valid <= 1'b0;
			out_data <= '0;
		end else begin
			wb_op <= addr_fault ? cpu_pkg::OP_NOP : mem_op;
			wb_rdst <= mem_rdst;
			wb_data <= (mem_op == cpu_pkg::OP_LDD) ? rd_data : mem_result;
			out_valid <= (mem_op == cpu_pkg::OP_OUT);
			if (mem_op == cpu_pkg::OP_OUT) begin
				out_data <= mem_result;
			end
		end
	end

	assign wb_we = cpu_pkg::writes_reg(wb_op);

	// the decoder traps opcodes 12 to 15, so none of them may reach this stage.
	a_legal_mem_op: assert property (@(posedge clk) disable iff (!arst_n)
		4'(mem_op) < 4'd12)
		else $error("an illegal opcode reached the memory stage");

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
	input  logic clk,
	input  logic arst_n,
	input  cpu_pkg::opcode_t ex_op,
	input  cpu_pkg::reg_addr_t ex_rdst,
	input  cpu_pkg::word_t ex_a,
	input  cpu_pkg::word_t ex_b,
	input  cpu_pkg::word_t ex_imm,
	input  cpu_pkg::pc_t ex_pc,
	input  cpu_pkg::fwd_sel_t fwd_a,
	input  cpu_pkg::fwd_sel_t fwd_b,
	input  cpu_pkg::word_t wb_data,
	input  logic flush_mem,
	output logic jump,
	output cpu_pkg::pc_t jump_target,
	output cpu_pkg::opcode_t mem_op,
	output cpu_pkg::reg_addr_t mem_rdst,
	output cpu_pkg::word_t mem_result,
	output cpu_pkg::word_t mem_addr,
	output cpu_pkg::pc_t mem_pc
);

	cpu_pkg::word_t opa;
	cpu_pkg::word_t opb;
	cpu_pkg::word_t result;
	logic z_flag;

	function automatic cpu_pkg::word_t pick(cpu_pkg::fwd_sel_t sel, cpu_pkg::word_t own,
		cpu_pkg::word_t from_mem, cpu_pkg::word_t from_wb);
		case (sel)
			cpu_pkg::FWD_MEM: return from_mem;
			cpu_pkg::FWD_WB: return from_wb;
			default: return own;
		endcase
	endfunction

	// operand a is the rdst value and operand b the rsrc value.
	assign opa = pick(fwd_a, ex_a, mem_result, wb_data);
	assign opb = pick(fwd_b, ex_b, mem_result, wb_data);

	always_comb begin
		case (ex_op)
			cpu_pkg::OP_MOV: result = opb;
			cpu_pkg::OP_ADD: result = opa + opb;
			cpu_pkg::OP_SUB: result = opa - opb;
			cpu_pkg::OP_AND: result = opa & opb;
			cpu_pkg::OP_OR: result = opa | opb;
			cpu_pkg::OP_LDI: result = ex_imm;
			// store data and the output value both come from rdst.
			cpu_pkg::OP_STD, cpu_pkg::OP_OUT: result = opa;
			default: result = '0;
		endcase
	end

	assign jump = (ex_op == cpu_pkg::OP_JMP) || (ex_op == cpu_pkg::OP_JZ && z_flag);
	assign jump_target = {16'd0, opa};

	// an instruction squashed by a memory fault must leave Z alone.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			z_flag <= 1'b0;
		end else if (!flush_mem && ex_op inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB,
			cpu_pkg::OP_AND, cpu_pkg::OP_OR}) begin
			z_flag <= (result == '0);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_op <= cpu_pkg::OP_NOP;
			mem_rdst <= '0;
			mem_result <= '0;
			mem_addr <= '0;
			mem_pc <= '0;
		end else begin
			mem_op <= flush_mem ? cpu_pkg::OP_NOP : ex_op;
			mem_rdst <= ex_rdst;
			mem_result <= result;
			mem_addr <= opb;
			mem_pc <= ex_pc;
		end
	end

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
	input  logic clk,
	input  logic arst_n,
	input  cpu_pkg::instr_t id_instr,
	input  cpu_pkg::pc_t id_pc,
	input  logic stall,
	input  logic flush_ex,
	input  logic jump,
	input  logic wb_we,
	input  cpu_pkg::reg_addr_t wb_rdst,
	input  cpu_pkg::word_t wb_data,
	output logic illegal,
	output cpu_pkg::opcode_t ex_op,
	output cpu_pkg::reg_addr_t ex_rdst,
	output cpu_pkg::reg_addr_t ex_rsrc,
	output cpu_pkg::word_t ex_a,
	output cpu_pkg::word_t ex_b,
	output cpu_pkg::word_t ex_imm,
	output cpu_pkg::pc_t ex_pc
);

	logic [3:0] op_bits;
	cpu_pkg::reg_addr_t f_rdst;
	cpu_pkg::reg_addr_t f_rsrc;
	cpu_pkg::word_t f_imm;
	cpu_pkg::word_t rd_a;
	cpu_pkg::word_t rd_b;
	cpu_pkg::word_t regs [8];

	assign op_bits = id_instr[cpu_pkg::OPCODE_MSB:cpu_pkg::OPCODE_LSB];
	assign f_rdst = id_instr[cpu_pkg::RDST_MSB:cpu_pkg::RDST_LSB];
	assign f_rsrc = id_instr[cpu_pkg::RSRC_MSB:cpu_pkg::RSRC_LSB];
	assign f_imm = {7'd0, id_instr[cpu_pkg::IMM_MSB:cpu_pkg::IMM_LSB]};

	// an instruction that a taken jump squashes never raises an exception.
	assign illegal = (op_bits >= 4'd12) && !jump;

	always_ff @(posedge clk) begin
		if (wb_we) begin
			regs[wb_rdst] <= wb_data;
		end
	end

	// Reads see the value being written back in the same cycle.
	assign rd_a = (wb_we && wb_rdst == f_rdst) ? wb_data : regs[f_rdst];
	assign rd_b = (wb_we && wb_rdst == f_rsrc) ? wb_data : regs[f_rsrc];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_op <= cpu_pkg::OP_NOP;
			ex_rdst <= '0;
			ex_rsrc <= '0;
			ex_a <= '0;
			ex_b <= '0;
			ex_imm <= '0;
			ex_pc <= '0;
		end else begin
			// a bubble only needs the opcode cleared.
			if (stall || flush_ex || jump) begin
				ex_op <= cpu_pkg::OP_NOP;
			end else begin
				ex_op <= cpu_pkg::opcode_t'(op_bits);
			end
			ex_rdst <= f_rdst;
			ex_rsrc <= f_rsrc;
			ex_a <= rd_a;
			ex_b <= rd_b;
			ex_imm <= f_imm;
			ex_pc <= id_pc;
		end
	end

endmodule

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage #(
	parameter cpu_pkg::pc_t RESET_ADDR = '0,
	parameter cpu_pkg::pc_t HANDLER_ADDR = 32'h100
) (
	input  logic clk,
	input  logic arst_n,
	output cpu_pkg::pc_t instr_addr,
	input  cpu_pkg::instr_t instr,
	input  logic stall,
	input  logic jump,
	input  cpu_pkg::pc_t jump_target,
	input  logic exc_redirect,
	input  logic flush_id,
	output cpu_pkg::instr_t id_instr,
	output cpu_pkg::pc_t id_pc
);

	// the exception redirect has the last word, then a taken jump, then the stall.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			instr_addr <= RESET_ADDR;
		end else if (exc_redirect) begin
			instr_addr <= HANDLER_ADDR;
		end else if (jump) begin
			instr_addr <= jump_target;
		end else if (!stall) begin
			instr_addr <= instr_addr + 32'd1;
		end
	end

	// an all-zero instruction word decodes as NOP.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_instr <= '0;
			id_pc <= '0;
		end else if (flush_id || jump) begin
			id_instr <= '0;
			id_pc <= '0;
		end else if (!stall) begin
			id_instr <= instr;
			id_pc <= instr_addr;
		end
	end

	// a redirect must never leave a stalled instruction held in IF/ID.
	a_redirect_clears_ifid: assert property (@(posedge clk) disable iff (!arst_n)
		exc_redirect |=> id_instr == '0)
		else $error("IF/ID kept an instruction across an exception redirect");

endmodule

// ==== source/cpu_pkg.sv ====
package cpu_pkg;

	localparam int WORD_W = 16;
	localparam int PC_W = 32;
	localparam int REG_ADDR_W = 3;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [PC_W-1:0] pc_t;
	typedef logic [15:0] instr_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// opcodes 12 to 15 are not assigned and trap as illegal.
	typedef enum logic [3:0] {
		OP_NOP = 4'd0,
		OP_MOV,
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_LDI,
		OP_LDD,
		OP_STD,
		OP_JZ,
		OP_JMP,
		OP_OUT = 4'd11
	} opcode_t;

	typedef enum logic [2:0] {
		CAUSE_NONE = 3'd0,
		CAUSE_ILLEGAL_OP = 3'd1,
		CAUSE_MEM_ADDR = 3'd2
	} cause_t;

	typedef enum logic [1:0] {
		FWD_NONE,
		FWD_MEM,
		FWD_WB
	} fwd_sel_t;

	localparam int OPCODE_MSB = 15;
	localparam int OPCODE_LSB = 12;
	localparam int RDST_MSB = 11;
	localparam int RDST_LSB = 9;
	localparam int RSRC_MSB = 8;
	localparam int RSRC_LSB = 6;
	localparam int IMM_MSB = 8;
	localparam int IMM_LSB = 0;

	// true for every operation that writes rdst in write-back.
	function automatic logic writes_reg(opcode_t op);
		return op inside {OP_MOV, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_LDI, OP_LDD};
	endfunction

endpackage
